//--- sdspi_pkg.sv
// command frame, response byte views and host/buffer port structs
// plus the fixed frames and tokens of the SPI-mode init sequence
package sdspi_pkg;

   // ******************************
   // card-facing types
   // ******************************
   typedef struct packed {
      logic [7:0]  start_index;    // 01 prefix + 6-bit index
      logic [31:0] arg;
      logic [7:0]  crc_end;        // crc7 + end bit
   } sd_cmd_t;

   typedef struct packed {
      logic       start;           // always 0 on the wire
      logic [6:0] status;
   } sd_r1_view_t;

   typedef struct packed {
      logic [2:0] unused;
      logic       start;
      logic [2:0] status;
      logic       end_bit;
   } sd_dresp_view_t;

   // one byte off MISO, seen as R1 after a command or as the data response after a write
   typedef union packed {
      sd_r1_view_t    r1;
      sd_dresp_view_t dr;
   } sd_resp_u;

   // ******************************
   // host side
   // ******************************
   typedef struct packed {
      logic        start;
      logic        write_mode;     // 1 = sector write
      logic [26:0] sector_addr;
   } host_req_t;

   typedef struct packed {
      logic idle;
      logic io_done;
      logic error;
   } host_stat_t;

   typedef struct packed {
      logic [7:0]  addr;
      logic        we;
      logic [15:0] wdata;
   } buf_port_t;

   // init frames with their fixed crc bytes
   localparam sd_cmd_t CMD0_FRAME   = 48'h40_0000_0000_95;
   localparam sd_cmd_t CMD8_FRAME   = 48'h48_0000_01aa_87;  // 2.7-3.6 V, check pattern aa
   localparam sd_cmd_t CMD55_FRAME  = 48'h77_0000_0000_65;
   localparam sd_cmd_t ACMD41_FRAME = 48'h69_4000_0000_77;  // hcs set

   localparam logic [5:0] CMD_READ_INDEX    = 6'd17;
   localparam logic [5:0] CMD_WRITE_INDEX   = 6'd24;
   localparam logic [7:0] TOKEN_START_BLOCK = 8'hfe;
   localparam logic [6:0] R1_READY          = 7'h00;
   localparam logic [6:0] R1_IDLE           = 7'h01;
   localparam logic [2:0] DR_ACCEPTED       = 3'b010;
   localparam int         BUF_WORDS         = 256;

endpackage

//--- sector_buf.sv
// 256 x 16 dual-port sector buffer
// port a belongs to the host, port b to the card data path
`timescale 1ns/1ps

module sector_buf (
   input  logic                 controller_clk,
   input  logic                 reset,
   input  sdspi_pkg::buf_port_t a_port,
   output logic [15:0]          a_rdata,
   input  logic [7:0]           b_addr,
   input  logic                 b_we,
   input  logic [15:0]          b_wdata,
   output logic [15:0]          b_rdata
);

   logic [15:0] mem [256];

   always_ff @(posedge controller_clk) begin
      if (a_port.we) mem[a_port.addr] <= a_port.wdata;
      if (b_we)      mem[b_addr]      <= b_wdata;
   end

   // one-clock read on both ports
   always_ff @(posedge controller_clk) begin
      if (reset) begin
         a_rdata <= '0;
         b_rdata <= '0;
      end else begin
         a_rdata <= mem[a_port.addr];
         b_rdata <= mem[b_addr];
      end
   end

endmodule

//--- sd_spi_clock.sv
// SCLK divider with rise/fall ticks in the controller clock domain
`timescale 1ns/1ps

module sd_spi_clock #(
   parameter int CLK_DIV = 2
) (
   input  logic controller_clk,
   input  logic reset,
   input  logic enable,
   output logic sclk,
   output logic rise_tick,
   output logic fall_tick
);

   localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

   logic [CW-1:0] div_cnt;
   logic          half_end;      // last controller clock of a half period

   assign half_end  = enable && (div_cnt == CW'(CLK_DIV - 1));
   assign rise_tick = half_end && !sclk;   // sclk goes high on this edge
   assign fall_tick = half_end && sclk;

   always_ff @(posedge controller_clk) begin
      if (reset || !enable) begin
         div_cnt <= '0;
         sclk    <= 1'b0;      // parked low
      end else if (half_end) begin
         div_cnt <= '0;
         sclk    <= ~sclk;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

endmodule

//--- sd_cmd_engine.sv
// SPI command phase: 48-bit frame out, wait for R1, optional R7 tail
`timescale 1ns/1ps

module sd_cmd_engine #(
   parameter int R1_TIMEOUT = 1023
) (
   input  logic                controller_clk,
   input  logic                reset,
   input  logic                rise_tick,
   input  logic                fall_tick,
   input  logic                miso,
   input  logic                cmd_go,
   input  sdspi_pkg::sd_cmd_t  cmd,
   input  logic                want_r7,
   output logic                cmd_mosi,
   output logic                cmd_done,
   output sdspi_pkg::sd_resp_u r1,
   output logic                timed_out
);

   localparam int CW = (R1_TIMEOUT > 63) ? $clog2(R1_TIMEOUT + 1) : 6;

   typedef enum logic [2:0] {
      S_IDLE,
      S_SHIFT,
      S_WAIT_R1,
      S_R1,
      S_R7
   } state_t;

   state_t        state;
   logic [47:0]   frame_sr;
   logic [CW-1:0] cnt;           // bit counter, also the R1 timeout
   logic          r7_pending;

   always_ff @(posedge controller_clk) begin
      if (reset) begin
         state      <= S_IDLE;
         cmd_mosi   <= 1'b1;
         cmd_done   <= 1'b0;
         timed_out  <= 1'b0;
         r7_pending <= 1'b0;
         cnt        <= '0;
      end else begin
         cmd_done <= 1'b0;
         if (fall_tick) cmd_mosi <= (state == S_SHIFT) ? frame_sr[47] : 1'b1;

         case (state)
            S_IDLE: if (cmd_go) begin
               frame_sr   <= cmd;
               r7_pending <= want_r7;
               timed_out  <= 1'b0;
               cnt        <= CW'(47);
               state      <= S_SHIFT;
            end
            // ******************************
            // frame out, msb first
            // ******************************
            S_SHIFT: if (fall_tick) begin
               frame_sr <= {frame_sr[46:0], 1'b1};
               if (cnt == '0) begin
                  cnt   <= CW'(R1_TIMEOUT);
                  state <= S_WAIT_R1;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            S_WAIT_R1: if (rise_tick) begin
               if (!miso) begin         // start bit of R1
                  r1    <= '0;
                  cnt   <= CW'(6);
                  state <= S_R1;
               end else if (cnt == '0) begin
                  timed_out <= 1'b1;
                  cmd_done  <= 1'b1;
                  state     <= S_IDLE;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            S_R1: if (rise_tick) begin
               r1 <= {r1[6:0], miso};
               if (cnt != '0) begin
                  cnt <= cnt - 1'b1;
               end else if (r7_pending) begin
                  cnt   <= CW'(31);
                  state <= S_R7;
               end else begin
                  cmd_done <= 1'b1;
                  state    <= S_IDLE;
               end
            end
            // r7 echo is clocked through and dropped
            S_R7: if (rise_tick) begin
               if (cnt == '0) begin
                  cmd_done <= 1'b1;
                  state    <= S_IDLE;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

//--- sd_block_engine.sv
// sector data phase for read and write, drives buffer port b
// owns MOSI while a block is in flight
`timescale 1ns/1ps

module sd_block_engine (
   input  logic        controller_clk,
   input  logic        reset,
   input  logic        rise_tick,
   input  logic        fall_tick,
   input  logic        miso,
   input  logic        cmd_mosi,
   input  logic        blk_go,
   input  logic        write,
   output logic        mosi,
   output logic        blk_done,
   output logic        blk_ok,
   output logic [7:0]  b_addr,
   output logic        b_we,
   output logic [15:0] b_wdata,
   input  logic [15:0] b_rdata
);
   import sdspi_pkg::*;

   typedef enum logic [3:0] {
      S_IDLE,
      S_RD_WAIT,
      S_RD_DATA,
      S_RD_CRC,
      S_WR_PRE,
      S_WR_DATA,
      S_WR_CRC,
      S_WR_RESP,
      S_WR_BUSY
   } state_t;

   state_t      state;
   logic [15:0] sh;
   logic [3:0]  bit_cnt;         // wraps 0 -> 15 between words
   logic [7:0]  word_idx;
   logic        blk_mosi;
   sd_resp_u    resp;
   logic [15:0] next_word;

   assign mosi      = (state == S_IDLE) ? cmd_mosi : blk_mosi;
   assign b_addr    = word_idx;
   assign next_word = {b_rdata[7:0], b_rdata[15:8]};   // low byte goes out first

   always_ff @(posedge controller_clk) begin
      if (reset) begin
         state    <= S_IDLE;
         blk_mosi <= 1'b1;
         blk_done <= 1'b0;
         blk_ok   <= 1'b0;
         b_we     <= 1'b0;
         bit_cnt  <= '0;
         word_idx <= '0;
      end else begin
         blk_done <= 1'b0;
         b_we     <= 1'b0;
         if (b_we) word_idx <= word_idx + 1'b1;   // step after the store

         case (state)
            S_IDLE: if (blk_go) begin
               word_idx <= '0;
               blk_ok   <= 1'b0;
               if (write) begin
                  sh      <= {8'hff, TOKEN_START_BLOCK};
                  bit_cnt <= 4'd15;
                  state   <= S_WR_PRE;
               end else begin
                  state <= S_RD_WAIT;
               end
            end
            // ******************************
            // read: token, 256 words, crc
            // ******************************
            S_RD_WAIT: if (rise_tick && !miso) begin   // last bit of fe
               bit_cnt <= 4'd15;
               state   <= S_RD_DATA;
            end
            S_RD_DATA: if (rise_tick) begin
               sh      <= {sh[14:0], miso};
               bit_cnt <= bit_cnt - 1'b1;
               if (bit_cnt == 4'd0) begin
                  b_wdata <= {sh[6:0], miso, sh[14:7]};   // first card byte low
                  b_we    <= 1'b1;
                  if (word_idx == 8'(BUF_WORDS - 1)) state <= S_RD_CRC;
               end
            end
            S_RD_CRC: if (rise_tick) begin
               bit_cnt <= bit_cnt - 1'b1;
               if (bit_cnt == 4'd0) begin
                  blk_ok   <= 1'b1;
                  blk_done <= 1'b1;
                  state    <= S_IDLE;
               end
            end
            // ******************************
            // write: ff fe, data, crc, response
            // ******************************
            S_WR_PRE: if (fall_tick) begin
               blk_mosi <= sh[15];
               sh       <= {sh[14:0], 1'b1};
               bit_cnt  <= bit_cnt - 1'b1;
               if (bit_cnt == 4'd0) begin
                  sh       <= next_word;
                  word_idx <= word_idx + 1'b1;
                  state    <= S_WR_DATA;
               end
            end
            S_WR_DATA: if (fall_tick) begin
               blk_mosi <= sh[15];
               sh       <= {sh[14:0], 1'b1};
               bit_cnt  <= bit_cnt - 1'b1;
               if (bit_cnt == 4'd0) begin
                  if (word_idx == 8'd0) begin      // index wrapped, last word out
                     state <= S_WR_CRC;
                  end else begin
                     sh       <= next_word;
                     word_idx <= word_idx + 1'b1;
                  end
               end
            end
            S_WR_CRC: if (fall_tick) begin
               blk_mosi <= 1'b1;
               bit_cnt  <= bit_cnt - 1'b1;
               if (bit_cnt == 4'd0) begin
                  bit_cnt <= 4'd8;                 // first sample still sees the crc tail
                  state   <= S_WR_RESP;
               end
            end
            S_WR_RESP: if (rise_tick) begin
               resp    <= {resp[6:0], miso};
               bit_cnt <= bit_cnt - 1'b1;
               if (bit_cnt == 4'd0) state <= S_WR_BUSY;
            end
            S_WR_BUSY: begin
               if (resp.dr.status != DR_ACCEPTED) begin
                  blk_done <= 1'b1;
                  state    <= S_IDLE;
               end else if (rise_tick && miso) begin   // card released busy
                  blk_ok   <= 1'b1;
                  blk_done <= 1'b1;
                  state    <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

//--- sd_ctrl.sv
// main FSM: card init, host handshake, command and block sequencing
`timescale 1ns/1ps

module sd_ctrl #(
   parameter int INIT_DELAY = 500
) (
   input  logic                  controller_clk,
   input  logic                  reset,
   input  logic                  rise_tick,
   input  sdspi_pkg::host_req_t  req,
   output sdspi_pkg::host_stat_t stat,
   output logic                  cs,
   output logic                  clk_en,
   output logic                  cmd_go,
   output sdspi_pkg::sd_cmd_t    cmd,
   output logic                  want_r7,
   input  logic                  cmd_done,
   input  sdspi_pkg::sd_resp_u   r1,
   input  logic                  timed_out,
   output logic                  blk_go,
   output logic                  write,
   input  logic                  blk_done,
   input  logic                  blk_ok
);
   import sdspi_pkg::*;

   localparam int DW = $clog2(INIT_DELAY + 1);

   typedef enum logic [3:0] {
      S_DELAY,
      S_CMD0,
      S_CMD8,
      S_CMD55,
      S_ACMD41,
      S_IDLE,
      S_XCMD,
      S_XBLK,
      S_DONE,
      S_FAIL
   } state_t;

   state_t        state;
   logic [DW-1:0] dly;

   function automatic sd_cmd_t xfer_frame(input logic wr, input logic [26:0] addr);
      sd_cmd_t f;
      f.start_index = {2'b01, wr ? CMD_WRITE_INDEX : CMD_READ_INDEX};
      f.arg         = {5'b00000, addr};
      f.crc_end     = 8'h01;          // crc ignored in spi mode
      return f;
   endfunction

   task automatic issue(input sd_cmd_t frame, input logic r7);
      cmd     <= frame;
      want_r7 <= r7;
      cmd_go  <= 1'b1;
   endtask

   // sclk stops only between transfers
   assign clk_en = !(state == S_IDLE && !req.start);

   always_ff @(posedge controller_clk) begin
      if (reset) begin
         state   <= S_DELAY;
         dly     <= DW'(INIT_DELAY);
         stat    <= '0;
         cs      <= 1'b1;
         cmd_go  <= 1'b0;
         want_r7 <= 1'b0;
         blk_go  <= 1'b0;
         write   <= 1'b0;
      end else begin
         cmd_go <= 1'b0;
         blk_go <= 1'b0;

         if (cmd_done && timed_out) begin    // no R1 at all
            stat.error <= 1'b1;
            state      <= S_FAIL;
         end else begin
            case (state)
               // ******************************
               // power-up sequence
               // ******************************
               S_DELAY: if (rise_tick) begin
                  if (dly != '0) begin
                     dly <= dly - 1'b1;
                  end else begin
                     cs    <= 1'b0;
                     issue(CMD0_FRAME, 1'b0);
                     state <= S_CMD0;
                  end
               end
               S_CMD0: if (cmd_done) begin
                  if (r1.r1.status == R1_IDLE) begin
                     issue(CMD8_FRAME, 1'b1);
                     state <= S_CMD8;
                  end else begin
                     state <= S_FAIL;
                  end
               end
               S_CMD8: if (cmd_done) begin
                  if (r1.r1.status == R1_IDLE) begin
                     issue(CMD55_FRAME, 1'b0);
                     state <= S_CMD55;
                  end else begin
                     state <= S_FAIL;
                  end
               end
               S_CMD55: if (cmd_done) begin
                  if (r1.r1.status == R1_IDLE) begin
                     issue(ACMD41_FRAME, 1'b0);
                     state <= S_ACMD41;
                  end else begin
                     state <= S_FAIL;
                  end
               end
               S_ACMD41: if (cmd_done) begin
                  if (r1.r1.status == R1_READY) begin
                     cs        <= 1'b1;
                     stat.idle <= 1'b1;
                     state     <= S_IDLE;
                  end else begin
                     issue(CMD8_FRAME, 1'b1);   // still idle, go round again
                     state <= S_CMD8;
                  end
               end
               // ******************************
               // host transfers
               // ******************************
               S_IDLE: if (rise_tick && req.start) begin
                  stat.idle  <= 1'b0;
                  stat.error <= 1'b0;
                  cs         <= 1'b0;
                  write      <= req.write_mode;
                  issue(xfer_frame(req.write_mode, req.sector_addr), 1'b0);
                  state      <= S_XCMD;
               end
               S_XCMD: if (cmd_done) begin
                  if (r1.r1.status == R1_READY) begin
                     blk_go <= 1'b1;
                     state  <= S_XBLK;
                  end else begin
                     stat.error <= 1'b1;
                     state      <= S_FAIL;
                  end
               end
               S_XBLK: if (blk_done) begin
                  if (blk_ok) begin
                     stat.io_done <= 1'b1;
                     state        <= S_DONE;
                  end else begin
                     stat.error <= 1'b1;
                     state      <= S_FAIL;
                  end
               end
               S_DONE: if (rise_tick && !req.start) begin
                  stat.io_done <= 1'b0;
                  stat.idle    <= 1'b1;
                  cs           <= 1'b1;
                  state        <= S_IDLE;
               end
               // back to the start of init
               S_FAIL: if (rise_tick) begin
                  cs    <= 1'b1;
                  dly   <= DW'(INIT_DELAY);
                  state <= S_DELAY;
               end
               default: state <= S_FAIL;
            endcase
         end
      end
   end

endmodule

//--- sdspi.sv
// SPI-mode SD card controller, top level
`timescale 1ns/1ps

module sdspi #(
   parameter int CLK_DIV    = 2,
   parameter int INIT_DELAY = 500,
   parameter int R1_TIMEOUT = 1023
) (
   input  logic                  controller_clk,
   input  logic                  reset,
   input  sdspi_pkg::host_req_t  req,
   output sdspi_pkg::host_stat_t stat,
   input  sdspi_pkg::buf_port_t  host_buf,
   output logic [15:0]           host_rdata,
   output logic                  sdcard_cs,
   output logic                  sdcard_mosi,
   output logic                  sdcard_sclk,
   input  logic                  sdcard_miso
);
   import sdspi_pkg::*;

   logic        rise_tick;
   logic        fall_tick;
   logic        clk_en;
   logic        cmd_go;
   logic        want_r7;
   logic        cmd_done;
   logic        timed_out;
   logic        cmd_mosi;
   sd_cmd_t     cmd;
   sd_resp_u    r1;
   logic        blk_go;
   logic        blk_write;
   logic        blk_done;
   logic        blk_ok;
   logic [7:0]  b_addr;
   logic        b_we;
   logic [15:0] b_wdata;
   logic [15:0] b_rdata;

   sector_buf i_buf (
      .controller_clk, .reset, .a_port(host_buf), .a_rdata(host_rdata),
      .b_addr, .b_we, .b_wdata, .b_rdata
   );

   sd_spi_clock #(.CLK_DIV(CLK_DIV)) i_clock (
      .controller_clk, .reset, .enable(clk_en), .sclk(sdcard_sclk), .rise_tick, .fall_tick
   );

   sd_cmd_engine #(.R1_TIMEOUT(R1_TIMEOUT)) i_cmd (
      .controller_clk, .reset, .rise_tick, .fall_tick, .miso(sdcard_miso),
      .cmd_go, .cmd, .want_r7, .cmd_mosi, .cmd_done, .r1, .timed_out
   );

   sd_block_engine i_blk (
      .controller_clk, .reset, .rise_tick, .fall_tick, .miso(sdcard_miso), .cmd_mosi,
      .blk_go, .write(blk_write), .mosi(sdcard_mosi), .blk_done, .blk_ok,
      .b_addr, .b_we, .b_wdata, .b_rdata
   );

   sd_ctrl #(.INIT_DELAY(INIT_DELAY)) i_ctrl (
      .controller_clk, .reset, .rise_tick, .req, .stat, .cs(sdcard_cs), .clk_en,
      .cmd_go, .cmd, .want_r7, .cmd_done, .r1, .timed_out,
      .blk_go, .write(blk_write), .blk_done, .blk_ok
   );

endmodule

//--- sd_card_model.sv
// SPI-mode SD card model for the testbench
// 4-sector memory, scripted R1/R7 answers, data token and busy
`timescale 1ns/1ps

module sd_card_model (
   input  logic cs,
   input  logic sclk,
   input  logic mosi,
   output logic miso
);

   localparam int M_CMD   = 0;
   localparam int M_TOKEN = 1;      // waiting for fe from the host
   localparam int M_DATA  = 2;

   logic [7:0]  mem [2048];
   int          acmd41_cnt = 0;
   bit          out_q [$];          // bits still to go out on miso
   logic [47:0] cmd_sr;
   int          cmd_bits = 0;
   logic        in_frame = 1'b0;
   int          mode = M_CMD;
   int          data_bits = 0;
   int          wr_base = 0;
   logic [7:0]  rx_byte;

   initial begin
      miso = 1'b1;
      for (int i = 0; i < 2048; i++) begin
         mem[i] = 8'(i) ^ 8'(i >> 3);
      end
   end

   task automatic push_byte(input logic [7:0] b);
      int k;
      for (k = 7; k >= 0; k--) begin
         out_q.push_back(b[k]);
      end
   endtask

   // ******************************
   // command decode and answer
   // ******************************
   task automatic answer(input logic [47:0] f);
      logic [5:0]  idx;
      logic [31:0] arg;
      int          base;
      idx = f[45:40];
      arg = f[39:8];
      base = int'(arg[1:0]) * 512;
      push_byte(8'hff);                // ncr gap
      case (idx)
         6'd0:  push_byte(8'h01);
         6'd8: begin
            push_byte(8'h01);
            push_byte(arg[31:24]);     // r7 echo
            push_byte(arg[23:16]);
            push_byte(arg[15:8]);
            push_byte(arg[7:0]);
         end
         6'd55: push_byte(8'h01);
         6'd41: begin
            acmd41_cnt++;
            push_byte((acmd41_cnt <= 2) ? 8'h01 : 8'h00);
         end
         6'd17: begin
            if (arg < 32'd4) begin
               push_byte(8'h00);
               push_byte(8'hff);       // token delay
               push_byte(8'hff);
               push_byte(8'hfe);
               for (int j = 0; j < 512; j++) begin
                  push_byte(mem[11'(base + j)]);
               end
               push_byte(8'hff);       // crc, not checked
               push_byte(8'hff);
            end else begin
               push_byte(8'h04);
            end
         end
         6'd24: begin
            if (arg < 32'd4) begin
               push_byte(8'h00);
               wr_base = base;
               mode = M_TOKEN;
            end else begin
               push_byte(8'h04);
            end
         end
         default: push_byte(8'h04);     // illegal command
      endcase
   endtask

   // mosi sampled on the rising sclk edge
   always @(posedge sclk or posedge cs) begin
      if (cs) begin
         out_q.delete();
         in_frame = 1'b0;
         mode = M_CMD;
      end else begin
         case (mode)
            M_CMD: begin
               if (!in_frame) begin
                  if (!mosi) begin     // first bit of a frame
                     in_frame = 1'b1;
                     cmd_sr = '0;
                     cmd_bits = 1;
                  end
               end else begin
                  cmd_sr = {cmd_sr[46:0], mosi};
                  cmd_bits++;
                  if (cmd_bits == 48) begin
                     in_frame = 1'b0;
                     answer(cmd_sr);
                  end
               end
            end
            M_TOKEN: if (!mosi) begin
               data_bits = 0;
               mode = M_DATA;
            end
            default: begin
               rx_byte = {rx_byte[6:0], mosi};
               data_bits++;
               if (data_bits % 8 == 0 && data_bits <= 4096) begin
                  mem[11'(wr_base + data_bits / 8 - 1)] = rx_byte;
               end
               if (data_bits == 4112) begin   // data plus crc
                  push_byte(8'h05);           // accepted
                  repeat (20) out_q.push_back(1'b0);
                  mode = M_CMD;
               end
            end
         endcase
      end
   end

   // miso changes on the falling edge
   always @(negedge sclk) begin
      if (!cs && out_q.size() > 0) begin
         miso = out_q.pop_front();
      end else begin
         miso = 1'b1;
      end
   end

endmodule

//--- tb_sdspi.sv
// testbench top for the SD SPI controller
// clock, reset, host stimulus, reference bytes, compare tasks, timeout
`timescale 1ns/1ps

module tb_sdspi;
   import sdspi_pkg::*;

   localparam int TIMEOUT_CYCLES = 400000;

   typedef logic [15:0] words_t [256];
   typedef logic [7:0]  sector_t [512];

   logic       controller_clk;
   logic       reset;
   host_req_t  req;
   host_stat_t stat;
   buf_port_t  host_buf;
   logic [15:0] host_rdata;
   logic       sdcard_cs;
   logic       sdcard_mosi;
   logic       sdcard_sclk;
   logic       sdcard_miso;

   int         errors = 0;
   int         tests = 0;
   int         failed_tests = 0;
   int         errs_mark = 0;
   int         cycles = 0;
   words_t     wr_words;
   words_t     zero_words;
   sector_t    card_bytes;
   sector_t    exp_bytes;
   host_stat_t end_stat;

   sdspi #(.INIT_DELAY(20)) i_sdspi (
      .controller_clk, .reset, .req, .stat, .host_buf, .host_rdata,
      .sdcard_cs, .sdcard_mosi, .sdcard_sclk, .sdcard_miso
   );

   sd_card_model i_card (
      .cs(sdcard_cs), .sclk(sdcard_sclk), .mosi(sdcard_mosi), .miso(sdcard_miso)
   );

   initial begin
      controller_clk = 1'b0;
      forever #2 controller_clk = ~controller_clk;
   end

   // run limit
   always @(posedge controller_clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", cycles);
         $display("sim failed");
         $finish;
      end
   end

   // card holds the first buffer byte in the low half of word 0
   function automatic void ref_card_bytes(input words_t w, output sector_t b);
      for (int i = 0; i < 256; i++) begin
         b[2 * i]     = w[i][7:0];
         b[2 * i + 1] = w[i][15:8];
      end
   endfunction

   function automatic host_stat_t make_stat(input logic idle, done, err);
      return '{idle: idle, io_done: done, error: err};
   endfunction

   // ******************************
   // compare tasks
   // ******************************
   task automatic check_word(input string name, input logic [15:0] got, exp);
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_stat(input string name, input host_stat_t got, exp);
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, exp);
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_bytes(input string name, input sector_t got, exp);
      for (int i = 0; i < 512; i++) begin
         if (got[i] !== exp[i]) begin
            errors++;
            $display("[FAIL] %0t %s[%0d] got %h expected %h", $time, name, i, got[i], exp[i]);
         end
      end
   endtask

   task automatic step();
      @(posedge controller_clk);
      #1;
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (errors == errs_mark) begin
         $display("test %0d %s: ok", tests, name);
      end else begin
         failed_tests++;
         $display("test %0d %s: failed", tests, name);
      end
      errs_mark = errors;
   endtask

   task automatic load_buffer(input words_t w);
      for (int i = 0; i < 256; i++) begin
         host_buf = '{addr: 8'(i), we: 1'b1, wdata: w[i]};
         step();
      end
      host_buf = '0;
   endtask

   task automatic compare_buffer(input words_t exp);
      for (int i = 0; i < 256; i++) begin
         host_buf = '{addr: 8'(i), we: 1'b0, wdata: 16'h0000};
         step();                       // rdata one clock later
         check_word($sformatf("host_rdata[%0d]", i), host_rdata, exp[i]);
      end
      host_buf = '0;
   endtask

   // one host request, start held for hold extra cycles after io_done
   task automatic run_transfer(input logic wr, input logic [26:0] sector, input int hold,
                               output host_stat_t fin);
      check_bit("sdcard_cs", sdcard_cs, 1'b1);       // deselected between transfers
      check_bit("sdcard_sclk", sdcard_sclk, 1'b0);   // parked while idle
      req = '{start: 1'b1, write_mode: wr, sector_addr: sector};
      step();
      while (stat.idle) step();        // accepted
      while (!stat.io_done && !stat.error) step();
      fin = stat;
      if (!fin.error) begin
         check_bit("sdcard_cs", sdcard_cs, 1'b0);
      end
      for (int i = 0; i < hold; i++) begin
         check_stat("stat", stat, make_stat(1'b0, 1'b1, 1'b0));
         step();
      end
      req.start = 1'b0;
      step();
      while (!stat.idle) begin
         if (fin.error && stat.io_done) begin
            errors++;
            $display("io_done rose at %0t after the card rejected the command", $time);
         end
         step();
      end
      check_bit("sdcard_cs", sdcard_cs, 1'b1);
   endtask

   initial begin
      void'($urandom(32'hea3d_c323));
      reset = 1'b1;
      req = '0;
      host_buf = '0;
      for (int i = 0; i < 256; i++) begin
         wr_words[i] = 16'($urandom);
         zero_words[i] = 16'h0000;
      end
      repeat (8) step();
      reset = 1'b0;

      // power-up
      check_stat("stat", stat, make_stat(1'b0, 1'b0, 1'b0));
      check_bit("sdcard_cs", sdcard_cs, 1'b1);
      check_bit("sdcard_mosi", sdcard_mosi, 1'b1);
      while (!stat.idle) step();
      check_word("acmd41_count", 16'(i_card.acmd41_cnt), 16'd3);
      finish_test("init");

      load_buffer(wr_words);
      run_transfer(1'b1, 27'd1, 0, end_stat);
      check_stat("stat", end_stat, make_stat(1'b0, 1'b1, 1'b0));
      for (int i = 0; i < 512; i++) begin
         card_bytes[i] = i_card.mem[11'(512 + i)];
      end
      ref_card_bytes(wr_words, exp_bytes);
      check_bytes("card_mem", card_bytes, exp_bytes);
      finish_test("write sector 1");

      load_buffer(zero_words);
      run_transfer(1'b0, 27'd1, 0, end_stat);
      check_stat("stat", end_stat, make_stat(1'b0, 1'b1, 1'b0));
      compare_buffer(wr_words);
      finish_test("read sector 1");

      load_buffer(zero_words);
      run_transfer(1'b0, 27'd1, 40, end_stat);
      check_stat("stat", stat, make_stat(1'b1, 1'b0, 1'b0));
      compare_buffer(wr_words);
      finish_test("handshake hold");

      // rejected sector, then recovery
      run_transfer(1'b0, 27'd9, 0, end_stat);
      check_stat("stat", end_stat, make_stat(1'b0, 1'b0, 1'b1));
      check_stat("stat", stat, make_stat(1'b1, 1'b0, 1'b1));
      load_buffer(zero_words);
      run_transfer(1'b0, 27'd1, 0, end_stat);
      check_stat("stat", end_stat, make_stat(1'b0, 1'b1, 1'b0));
      compare_buffer(wr_words);
      finish_test("error and recovery");

      $display("tests: %0d, failed tests: %0d, errors: %0d", tests, failed_tests, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- project.f
sdspi_pkg.sv
sector_buf.sv
sd_spi_clock.sv
sd_cmd_engine.sv
sd_block_engine.sv
sd_ctrl.sv
sdspi.sv
sd_card_model.sv
tb_sdspi.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module tb_sdspi -f project.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -qx "sim passed"; then
   exit 0
fi
exit 1
